/* design/ctrl_pkg.sv */
// Shared types for the pipeline controller
// Enums, cause codes, stage status summaries and the control word

package ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////

  // Main controller states
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    FUNCTIONAL  = 3'd2,
    SLEEP       = 3'd3,
    DEBUG_TAKEN = 3'd4
  } ctrl_state_e;

  // Debug status, one-hot
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } debug_state_e;

  localparam int unsigned HAVERESET_IDX = 0;
  localparam int unsigned RUNNING_IDX   = 1;
  localparam int unsigned HALTED_IDX    = 2;

  // PC source select
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_DRET      = 3'd4
  } pc_mux_e;

  // Trap target select, used with PC_EXCEPTION
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_DBD       = 2'd2,
    EXC_PC_DBE       = 2'd3
  } exc_pc_mux_e;

  // Oldest stage holding a valid instruction
  typedef enum logic [1:0] {
    SAVE_IF = 2'd0,
    SAVE_ID = 2'd1,
    SAVE_EX = 2'd2,
    SAVE_WB = 2'd3
  } save_sel_e;

  ////////////////////////////////////////////////////////////
  // Cause codes (mcause layout)
  ////////////////////////////////////////////////////////////

  localparam logic [4:0] EXC_CAUSE_INSTR_BUS_FAULT = 5'd1;
  localparam logic [4:0] EXC_CAUSE_ILLEGAL_INSN    = 5'd2;
  localparam logic [4:0] EXC_CAUSE_BREAKPOINT      = 5'd3;
  localparam logic [4:0] EXC_CAUSE_ECALL_MMODE     = 5'd11;

  typedef struct packed {
    logic       irq_flag;
    logic [4:0] code;
  } csr_cause_t;

  ////////////////////////////////////////////////////////////
  // Stage status summaries
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic instr_valid;
    logic jump_insn;
    // Jump target operand not ready yet
    logic jr_stall;
  } id_status_t;

  typedef struct packed {
    logic instr_valid;
    // Branch with a taken decision
    logic branch_in_ex;
  } ex_status_t;

  typedef struct packed {
    logic instr_valid;
    logic bus_err;
    logic illegal_insn;
    logic ecall_insn;
    logic ebrk_insn;
    logic wfi_insn;
    logic dret_insn;
    logic lsu_en;
  } wb_status_t;

  // Decoded pipeline events
  typedef struct packed {
    logic       exception_wb;
    logic [4:0] exc_cause;
    logic       wfi_wb;
    logic       dret_wb;
    logic       branch_taken_ex;
    logic       jump_taken_id;
    save_sel_e  oldest;
  } pipe_events_t;

  // Debug and interrupt request summary
  typedef struct packed {
    logic       pending_debug;
    logic       debug_allowed;
    logic       pending_irq;
    logic       irq_allowed;
    logic [4:0] irq_id;
  } halt_req_t;

  // Control word back to the stages
  typedef struct packed {
    logic        ctrl_busy;
    logic        instr_req;
    logic        pc_set;
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
    logic        halt_if;
    logic        halt_id;
    logic        halt_ex;
    logic        halt_wb;
    logic        kill_if;
    logic        kill_id;
    logic        kill_ex;
    logic        kill_wb;
    logic        irq_ack;
    logic [4:0]  irq_id;
    logic        csr_save_if;
    logic        csr_save_id;
    logic        csr_save_ex;
    logic        csr_save_wb;
    logic        csr_save_cause;
    csr_cause_t  csr_cause;
    logic        csr_restore_dret;
    logic        debug_csr_save;
    logic        debug_mode;
    logic        debug_havereset;
    logic        debug_running;
    logic        debug_halted;
  } ctrl_fsm_t;

endpackage

/* design/pipe_event_decode.sv */
// Pipeline event decoder
// Qualifies stage flags and finds the oldest valid stage

`timescale 1ns/10ps

module pipe_event_decode import ctrl_pkg::*; (
  input  id_status_t   id_status_i,
  input  ex_status_t   ex_status_i,
  input  wb_status_t   wb_status_i,
  output pipe_events_t events_o
);

  logic wb_fault;

  // Any trap source on a valid WB instruction
  assign wb_fault = wb_status_i.bus_err || wb_status_i.illegal_insn ||
                    wb_status_i.ecall_insn || wb_status_i.ebrk_insn;

  always_comb begin
    events_o = '0;

    ////////////////////////////////////////////////////////////
    // WB events
    ////////////////////////////////////////////////////////////
    events_o.exception_wb = wb_fault && wb_status_i.instr_valid;

    // Fixed priority, fetch fault first, ebreak last
    if (wb_status_i.bus_err) begin
      events_o.exc_cause = EXC_CAUSE_INSTR_BUS_FAULT;
    end else if (wb_status_i.illegal_insn) begin
      events_o.exc_cause = EXC_CAUSE_ILLEGAL_INSN;
    end else if (wb_status_i.ecall_insn) begin
      events_o.exc_cause = EXC_CAUSE_ECALL_MMODE;
    end else begin
      events_o.exc_cause = EXC_CAUSE_BREAKPOINT;
    end

    events_o.wfi_wb  = wb_status_i.wfi_insn && wb_status_i.instr_valid;
    events_o.dret_wb = wb_status_i.dret_insn && wb_status_i.instr_valid;

    // Taken branch resolved in EX
    events_o.branch_taken_ex = ex_status_i.branch_in_ex && ex_status_i.instr_valid;

    // Jump in ID, only once the target register is available
    events_o.jump_taken_id = id_status_i.jump_insn && id_status_i.instr_valid &&
                             !id_status_i.jr_stall;

    // Oldest valid stage; IF always holds a valid next PC
    if (wb_status_i.instr_valid) begin
      events_o.oldest = SAVE_WB;
    end else if (ex_status_i.instr_valid) begin
      events_o.oldest = SAVE_EX;
    end else if (id_status_i.instr_valid) begin
      events_o.oldest = SAVE_ID;
    end else begin
      events_o.oldest = SAVE_IF;
    end
  end

  // No branch redirect from a bubble in EX
  always_comb begin
    assert final (!events_o.branch_taken_ex || ex_status_i.instr_valid)
      else $error("branch taken without a valid EX instruction");
  end

endmodule

/* design/halt_req_arbiter.sv */
// Halt request arbiter
// Sticky debug request and pending/allowed flags for debug and interrupts

`timescale 1ns/10ps

module halt_req_arbiter import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       debug_req_i,
  input  logic       irq_req_i,
  input  logic [4:0] irq_id_i,
  input  wb_status_t wb_status_i,
  input  logic       debug_mode_i,
  output halt_req_t  halt_req_o
);

  // Remembers a debug request pulse until debug mode is reached
  logic debug_req_q;
  logic lsu_in_wb;

  ////////////////////////////////////////////////////////////
  // Sticky debug request
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q <= 1'b0;
    end else begin
      if (debug_req_i) begin
        debug_req_q <= 1'b1;
      end else if (debug_mode_i) begin
        // Request served
        debug_req_q <= 1'b0;
      end
    end
  end

  // LSU instruction in WB must finish, so it cannot be killed
  assign lsu_in_wb = wb_status_i.lsu_en && wb_status_i.instr_valid;

  always_comb begin
    halt_req_o = '0;

    // Live pulse counts in the same cycle
    halt_req_o.pending_debug = (debug_req_i || debug_req_q) && !debug_mode_i;
    halt_req_o.debug_allowed = !lsu_in_wb;

    // Interrupts are masked in debug mode
    halt_req_o.pending_irq = irq_req_i && !debug_mode_i;
    halt_req_o.irq_allowed = !lsu_in_wb;
    halt_req_o.irq_id      = irq_id_i;
  end

  // Sticky request must drop once debug mode is entered
  a_sticky_clear : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(debug_mode_i) && !debug_req_i |=> !debug_req_q
  ) else $error("sticky debug request held after debug mode entry");

endmodule

/* design/ctrl_sequencer.sv */
// Pipeline control sequencer
// Main controller FSM, debug-mode flop and debug status FSM

`timescale 1ns/10ps

module ctrl_sequencer import ctrl_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         fetch_enable_i,
  input  logic         irq_wu_i,
  input  pipe_events_t events_i,
  input  halt_req_t    halt_req_i,
  output ctrl_fsm_t    ctrl_fsm_o
);

  ctrl_state_e  ctrl_fsm_cs;
  ctrl_state_e  ctrl_fsm_ns;
  debug_state_e debug_fsm_cs;
  debug_state_e debug_fsm_ns;
  logic         debug_mode_q;
  logic         debug_mode_n;
  logic         take_debug;
  logic         take_irq;
  logic         req_blocked;
  logic         wake_from_sleep;
  ctrl_fsm_t    ctrl;

  // Flush the whole pipeline
  function automatic ctrl_fsm_t kill_all(ctrl_fsm_t c);
    ctrl_fsm_t r;
    r         = c;
    r.kill_if = 1'b1;
    r.kill_id = 1'b1;
    r.kill_ex = 1'b1;
    r.kill_wb = 1'b1;
    return r;
  endfunction

  // Save the PC of the oldest valid stage
  function automatic ctrl_fsm_t save_oldest(ctrl_fsm_t c, save_sel_e sel);
    ctrl_fsm_t r;
    r = c;
    case (sel)
      SAVE_WB: r.csr_save_wb = 1'b1;
      SAVE_EX: r.csr_save_ex = 1'b1;
      SAVE_ID: r.csr_save_id = 1'b1;
      default: r.csr_save_if = 1'b1;
    endcase
    return r;
  endfunction

  assign take_debug = halt_req_i.pending_debug && halt_req_i.debug_allowed;
  assign take_irq   = halt_req_i.pending_irq && halt_req_i.irq_allowed;

  // Request waiting for an LSU instruction to leave WB
  assign req_blocked = (halt_req_i.pending_debug && !halt_req_i.debug_allowed) ||
                       (halt_req_i.pending_irq && !halt_req_i.irq_allowed);

  assign wake_from_sleep = irq_wu_i || halt_req_i.pending_debug || debug_mode_q;

  ////////////////////////////////////////////////////////////
  // Main FSM, next state and control word
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns     = ctrl_fsm_cs;
    debug_mode_n    = debug_mode_q;
    ctrl            = '0;
    ctrl.ctrl_busy  = 1'b1;
    ctrl.instr_req  = 1'b1;
    ctrl.pc_mux     = PC_BOOT;
    ctrl.exc_pc_mux = EXC_PC_IRQ;

    case (ctrl_fsm_cs)
      RESET: begin
        ctrl.instr_req = 1'b0;
        if (fetch_enable_i) begin
          ctrl_fsm_ns = BOOT_SET;
        end
      end
      // Boot redirect one cycle after fetch enable
      BOOT_SET: begin
        ctrl.pc_set = 1'b1;
        ctrl.pc_mux = PC_BOOT;
        ctrl_fsm_ns = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (take_debug) begin
          // Freeze everything, redirect next cycle
          ctrl.halt_if = 1'b1;
          ctrl.halt_id = 1'b1;
          ctrl.halt_ex = 1'b1;
          ctrl.halt_wb = 1'b1;
          ctrl_fsm_ns  = DEBUG_TAKEN;
        end else if (take_irq) begin
          ctrl                = kill_all(ctrl);
          ctrl.pc_set         = 1'b1;
          ctrl.pc_mux         = PC_EXCEPTION;
          ctrl.exc_pc_mux     = EXC_PC_IRQ;
          ctrl.irq_ack        = 1'b1;
          ctrl.irq_id         = halt_req_i.irq_id;
          ctrl.csr_save_cause = 1'b1;
          ctrl.csr_cause      = '{irq_flag: 1'b1, code: halt_req_i.irq_id};
          ctrl                = save_oldest(ctrl, events_i.oldest);
        end else begin
          // Stop issue so the blocked request can be taken at a bubble
          ctrl.halt_id = req_blocked;

          if (events_i.exception_wb) begin
            ctrl            = kill_all(ctrl);
            ctrl.pc_set     = 1'b1;
            ctrl.pc_mux     = PC_EXCEPTION;
            ctrl.exc_pc_mux = debug_mode_q ? EXC_PC_DBE : EXC_PC_EXCEPTION;
            ctrl.csr_save_wb = 1'b1;
            // Trap CSRs stay untouched in debug mode
            ctrl.csr_save_cause = !debug_mode_q;
            ctrl.csr_cause      = '{irq_flag: 1'b0, code: events_i.exc_cause};
          end else if (events_i.wfi_wb) begin
            // EX and WB drain before sleeping
            if (!debug_mode_q) begin
              ctrl.halt_if   = 1'b1;
              ctrl.halt_id   = 1'b1;
              ctrl.instr_req = 1'b0;
              ctrl_fsm_ns    = SLEEP;
            end
          end else if (events_i.dret_wb) begin
            ctrl.kill_if          = 1'b1;
            ctrl.kill_id          = 1'b1;
            ctrl.kill_ex          = 1'b1;
            ctrl.pc_set           = 1'b1;
            ctrl.pc_mux           = PC_DRET;
            ctrl.csr_restore_dret = 1'b1;
            debug_mode_n          = 1'b0;
          end else if (events_i.branch_taken_ex) begin
            ctrl.kill_if = 1'b1;
            ctrl.kill_id = 1'b1;
            ctrl.pc_set  = 1'b1;
            ctrl.pc_mux  = PC_BRANCH;
          end else if (events_i.jump_taken_id) begin
            ctrl.kill_if = 1'b1;
            ctrl.pc_set  = 1'b1;
            ctrl.pc_mux  = PC_JUMP;
          end
        end
      end
      SLEEP: begin
        ctrl.ctrl_busy = 1'b0;
        ctrl.instr_req = 1'b0;
        // Holding WB halts the stages behind it
        ctrl.halt_wb   = 1'b1;
        if (wake_from_sleep) begin
          ctrl.ctrl_busy = 1'b1;
          ctrl_fsm_ns    = FUNCTIONAL;
        end
      end
      DEBUG_TAKEN: begin
        ctrl                = kill_all(ctrl);
        ctrl.pc_set         = 1'b1;
        ctrl.pc_mux         = PC_EXCEPTION;
        ctrl.exc_pc_mux     = EXC_PC_DBD;
        ctrl.csr_save_cause = 1'b1;
        ctrl.debug_csr_save = 1'b1;
        ctrl                = save_oldest(ctrl, events_i.oldest);
        debug_mode_n        = 1'b1;
        ctrl_fsm_ns         = FUNCTIONAL;
      end
      default: begin
        ctrl.instr_req = 1'b0;
        ctrl_fsm_ns    = RESET;
      end
    endcase

    ctrl.debug_mode      = debug_mode_q;
    ctrl.debug_havereset = debug_fsm_cs[HAVERESET_IDX];
    ctrl.debug_running   = debug_fsm_cs[RUNNING_IDX];
    ctrl.debug_halted    = debug_fsm_cs[HALTED_IDX];
  end

  assign ctrl_fsm_o = ctrl;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ctrl_fsm_cs  <= RESET;
      debug_mode_q <= 1'b0;
      debug_fsm_cs <= HAVERESET;
    end else begin
      ctrl_fsm_cs  <= ctrl_fsm_ns;
      debug_mode_q <= debug_mode_n;
      debug_fsm_cs <= debug_fsm_ns;
    end
  end

  ////////////////////////////////////////////////////////////
  // Debug status FSM
  ////////////////////////////////////////////////////////////

  // Tracks debug_mode_n so the status moves with debug mode itself
  always_comb begin
    debug_fsm_ns = debug_fsm_cs;
    case (debug_fsm_cs)
      HAVERESET: begin
        if (debug_mode_n) begin
          debug_fsm_ns = HALTED;
        end else if (ctrl_fsm_ns == BOOT_SET) begin
          debug_fsm_ns = RUNNING;
        end
      end
      RUNNING: begin
        if (debug_mode_n) begin
          debug_fsm_ns = HALTED;
        end
      end
      HALTED: begin
        if (!debug_mode_n) begin
          debug_fsm_ns = RUNNING;
        end
      end
      default: debug_fsm_ns = HAVERESET;
    endcase
  end

  a_irq_ack_redirect : assert property (
    @(posedge clk) disable iff (!rst_n)
    ctrl.irq_ack |-> ctrl.pc_set
  ) else $error("irq_ack without a PC redirect");

  a_single_save : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0({ctrl.csr_save_if, ctrl.csr_save_id, ctrl.csr_save_ex, ctrl.csr_save_wb})
  ) else $error("more than one csr_save stage selected");

  a_legal_state : assert property (
    @(posedge clk) disable iff (!rst_n)
    ctrl_fsm_cs inside {RESET, BOOT_SET, FUNCTIONAL, SLEEP, DEBUG_TAKEN}
  ) else $error("controller FSM in an illegal state");

endmodule

/* design/pipe_ctrl_top.sv */
// Pipeline controller top level
// Event decoder and halt arbiter feed the control sequencer

`timescale 1ns/10ps

module pipe_ctrl_top import ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_enable_i,
  input  id_status_t id_status_i,
  input  ex_status_t ex_status_i,
  input  wb_status_t wb_status_i,
  input  logic       irq_req_i,
  input  logic [4:0] irq_id_i,
  input  logic       irq_wu_i,
  input  logic       debug_req_i,
  output ctrl_fsm_t  ctrl_fsm_o
);

  pipe_events_t events;
  halt_req_t    halt_req;

  pipe_event_decode u_event_decode (
    .id_status_i (id_status_i),
    .ex_status_i (ex_status_i),
    .wb_status_i (wb_status_i),
    .events_o    (events)
  );

  // Registered debug mode closes the loop back to the arbiter
  halt_req_arbiter u_halt_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .debug_req_i  (debug_req_i),
    .irq_req_i    (irq_req_i),
    .irq_id_i     (irq_id_i),
    .wb_status_i  (wb_status_i),
    .debug_mode_i (ctrl_fsm_o.debug_mode),
    .halt_req_o   (halt_req)
  );

  ctrl_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .irq_wu_i       (irq_wu_i),
    .events_i       (events),
    .halt_req_i     (halt_req),
    .ctrl_fsm_o     (ctrl_fsm_o)
  );

endmodule

/* tb/tb_pipe_ctrl.sv */
// Testbench for the pipeline controller
// Directed and random phases checked by concurrent assertions

`timescale 1ns/10ps

module tb_pipe_ctrl import ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  // Phase lengths in cycles set the watchdog limit
  localparam int RUN_CYCLES = 5 + 16 + 40 + 48 + 24 + 24 + 40;
  localparam int TIMEOUT_NS = (RUN_CYCLES + 50) * CLK_PERIOD;

  localparam int PH_BOOT  = 1;
  localparam int PH_EXC   = 2;
  localparam int PH_IRQ   = 3;
  localparam int PH_BR    = 4;
  localparam int PH_SLEEP = 5;
  localparam int PH_DBG   = 6;

  logic       clk;
  logic       rst_n;
  logic       fetch_enable_i;
  id_status_t id_st;
  ex_status_t ex_st;
  wb_status_t wb_st;
  logic       irq_req_i;
  logic [4:0] irq_id_i;
  logic       irq_wu_i;
  logic       debug_req_i;
  ctrl_fsm_t  ctrl;

  int     phase;
  integer seed;
  int     err_boot;
  int     err_exc;
  int     err_irq;
  int     err_br;
  int     err_sleep;
  int     err_dbg;
  logic   booted;
  logic   sleep_exp;
  logic   dbg_wait;
  logic   lsu_in_wb;

  pipe_ctrl_top dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .id_status_i    (id_st),
    .ex_status_i    (ex_st),
    .wb_status_i    (wb_st),
    .irq_req_i      (irq_req_i),
    .irq_id_i       (irq_id_i),
    .irq_wu_i       (irq_wu_i),
    .debug_req_i    (debug_req_i),
    .ctrl_fsm_o     (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////

  // Fault priority is bus error, illegal, ecall, then breakpoint
  function automatic logic [4:0] fault_cause(wb_status_t w);
    if (w.bus_err) return EXC_CAUSE_INSTR_BUS_FAULT;
    if (w.illegal_insn) return EXC_CAUSE_ILLEGAL_INSN;
    if (w.ecall_insn) return EXC_CAUSE_ECALL_MMODE;
    return EXC_CAUSE_BREAKPOINT;
  endfunction

  // Expected save bits as {wb, ex, id, if}
  function automatic logic [3:0] oldest_onehot(wb_status_t w, ex_status_t e, id_status_t d);
    if (w.instr_valid) return 4'b1000;
    if (e.instr_valid) return 4'b0100;
    if (d.instr_valid) return 4'b0010;
    return 4'b0001;
  endfunction

  function automatic void log_error(string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
  endfunction

  assign lsu_in_wb = wb_st.instr_valid && wb_st.lsu_en;

  // Expectation trackers run on pre-edge values
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      booted    <= 1'b0;
      sleep_exp <= 1'b0;
      dbg_wait  <= 1'b0;
    end else begin
      if (ctrl.pc_set && ctrl.pc_mux == PC_BOOT) begin
        booted <= 1'b1;
      end
      if (sleep_exp && irq_wu_i) begin
        sleep_exp <= 1'b0;
      end else if (phase == PH_SLEEP && wb_st.instr_valid && wb_st.wfi_insn) begin
        sleep_exp <= 1'b1;
      end
      if (phase == PH_DBG && debug_req_i) begin
        dbg_wait <= 1'b1;
      end else if (dbg_wait && !lsu_in_wb) begin
        dbg_wait <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Checking assertions
  ////////////////////////////////////////////////////////////

  a_reset_vals : assert property (@(posedge clk)
    $rose(rst_n) |-> !ctrl.instr_req && !ctrl.pc_set && !ctrl.debug_mode && ctrl.debug_havereset)
    else begin err_boot++; log_error("bad control word after reset"); end

  a_boot_set : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(fetch_enable_i) |=> ctrl.pc_set && ctrl.pc_mux == PC_BOOT && ctrl.debug_running)
    else begin err_boot++; log_error("no boot redirect after fetch enable"); end

  a_boot_fetch : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_BOOT && booted |-> ctrl.instr_req)
    else begin err_boot++; log_error("instr_req low after boot"); end

  a_exception : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_EXC && wb_st.instr_valid &&
    (wb_st.bus_err || wb_st.illegal_insn || wb_st.ecall_insn || wb_st.ebrk_insn)
    |-> ctrl.kill_if && ctrl.kill_id && ctrl.kill_ex && ctrl.kill_wb && ctrl.pc_set &&
        ctrl.pc_mux == PC_EXCEPTION && ctrl.exc_pc_mux == EXC_PC_EXCEPTION &&
        ctrl.csr_save_wb && ctrl.csr_save_cause &&
        ctrl.csr_cause == {1'b0, fault_cause(wb_st)})
    else begin err_exc++; log_error("wrong exception response"); end

  a_irq_taken : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_IRQ && irq_req_i && !lsu_in_wb
    |-> ctrl.irq_ack && ctrl.irq_id == irq_id_i && ctrl.csr_cause == {1'b1, irq_id_i} &&
        ctrl.pc_set && ctrl.pc_mux == PC_EXCEPTION && ctrl.exc_pc_mux == EXC_PC_IRQ &&
        ctrl.csr_save_cause &&
        {ctrl.csr_save_wb, ctrl.csr_save_ex, ctrl.csr_save_id, ctrl.csr_save_if} ==
        oldest_onehot(wb_st, ex_st, id_st))
    else begin err_irq++; log_error("wrong interrupt acknowledge"); end

  a_irq_blocked : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_IRQ && irq_req_i && lsu_in_wb |-> !ctrl.irq_ack && ctrl.halt_id)
    else begin err_irq++; log_error("interrupt not held off by LSU in WB"); end

  a_branch : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_BR && ex_st.instr_valid && ex_st.branch_in_ex
    |-> ctrl.kill_if && ctrl.kill_id && !ctrl.kill_ex && !ctrl.kill_wb && ctrl.pc_set &&
        ctrl.pc_mux == PC_BRANCH)
    else begin err_br++; log_error("wrong branch redirect"); end

  a_jump : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_BR && !(ex_st.instr_valid && ex_st.branch_in_ex) &&
    id_st.instr_valid && id_st.jump_insn && !id_st.jr_stall
    |-> ctrl.kill_if && !ctrl.kill_id && !ctrl.kill_ex && !ctrl.kill_wb && ctrl.pc_set &&
        ctrl.pc_mux == PC_JUMP)
    else begin err_br++; log_error("wrong jump redirect"); end

  a_jump_stall : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_BR && !(ex_st.instr_valid && ex_st.branch_in_ex) &&
    id_st.instr_valid && id_st.jump_insn && id_st.jr_stall |-> !ctrl.pc_set)
    else begin err_br++; log_error("jump taken during jr_stall"); end

  a_asleep : assert property (@(posedge clk) disable iff (!rst_n)
    sleep_exp && !irq_wu_i |-> !ctrl.ctrl_busy && !ctrl.instr_req)
    else begin err_sleep++; log_error("controller busy while asleep"); end

  a_wake : assert property (@(posedge clk) disable iff (!rst_n)
    sleep_exp && irq_wu_i |-> ctrl.ctrl_busy)
    else begin err_sleep++; log_error("ctrl_busy low in the wake cycle"); end

  a_dbg_hold : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_DBG && (debug_req_i || dbg_wait) && lsu_in_wb |-> ctrl.halt_id)
    else begin err_dbg++; log_error("halt_id low with debug request waiting"); end

  a_dbg_entry : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_DBG && dbg_wait && !lsu_in_wb
    |-> ctrl.halt_if && ctrl.halt_id && ctrl.halt_ex && ctrl.halt_wb
        ##1 ctrl.pc_set && ctrl.pc_mux == PC_EXCEPTION && ctrl.exc_pc_mux == EXC_PC_DBD &&
            ctrl.debug_csr_save
        ##1 ctrl.debug_mode && ctrl.debug_halted)
    else begin err_dbg++; log_error("wrong debug entry sequence"); end

  a_dret : assert property (@(posedge clk) disable iff (!rst_n)
    phase == PH_DBG && ctrl.debug_mode && wb_st.instr_valid && wb_st.dret_insn
    |-> ctrl.pc_set && ctrl.pc_mux == PC_DRET && ctrl.csr_restore_dret
        ##1 !ctrl.debug_mode && !ctrl.debug_halted && ctrl.debug_running)
    else begin err_dbg++; log_error("wrong dret exit"); end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic report_phase(input string name, input int fails);
    $display("phase %s done, %0d failure(s)", name, fails);
  endtask

  task automatic inject_fault(input logic [3:0] f);
    logic [31:0] rnd;
    rnd = $random(seed);
    @(posedge clk);
    wb_st <= '{instr_valid: 1'b1, bus_err: f[3], illegal_insn: f[2], ecall_insn: f[1],
               ebrk_insn: f[0], default: 1'b0};
    id_st <= rnd[2:0];
    ex_st <= rnd[4:3];
    @(posedge clk);
    wb_st <= '0;
  endtask

  task automatic wait_debug_mode(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!ctrl.debug_mode && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (!ctrl.debug_mode) begin
      err_dbg++;
      $display("Debug mode was not entered within %0d cycles", max_cycles);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    int          total;
    seed           = 32'h2b56;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    id_st          = '0;
    ex_st          = '0;
    wb_st          = '0;
    irq_req_i      = 1'b0;
    irq_id_i       = '0;
    irq_wu_i       = 1'b0;
    debug_req_i    = 1'b0;
    phase          = PH_BOOT;
    {err_boot, err_exc, err_irq, err_br, err_sleep, err_dbg} = '0;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Boot
    repeat (2) @(posedge clk);
    fetch_enable_i <= 1'b1;
    repeat (10) @(posedge clk);
    report_phase("boot", err_boot);

    // Exceptions with every fault mix
    phase <= PH_EXC;
    for (int k = 1; k < 16; k++) begin
      inject_fault(k[3:0]);
    end
    @(posedge clk);
    id_st <= '0;
    ex_st <= '0;
    report_phase("exc", err_exc);

    // Interrupts with random stage fill
    // Odd passes park an LSU instruction in WB
    phase <= PH_IRQ;
    for (int k = 0; k < 14; k++) begin
      rnd = $random(seed);
      @(posedge clk);
      irq_req_i <= 1'b1;
      irq_id_i  <= rnd[4:0];
      id_st     <= rnd[7:5];
      ex_st     <= rnd[9:8];
      wb_st     <= '{instr_valid: rnd[10] || k[0], lsu_en: k[0], default: 1'b0};
      @(posedge clk);
      irq_req_i <= 1'b0;
      wb_st     <= '0;
    end
    @(posedge clk);
    report_phase("irq", err_irq);

    // Branch, jump and stalled jump first, then random mixes
    phase <= PH_BR;
    for (int k = 0; k < 18; k++) begin
      rnd = $random(seed);
      @(posedge clk);
      case (k)
        0: begin
          id_st <= '0;
          ex_st <= '{instr_valid: 1'b1, branch_in_ex: 1'b1};
        end
        1: begin
          id_st <= '{instr_valid: 1'b1, jump_insn: 1'b1, jr_stall: 1'b0};
          ex_st <= '0;
        end
        2: begin
          id_st <= '{instr_valid: 1'b1, jump_insn: 1'b1, jr_stall: 1'b1};
          ex_st <= '0;
        end
        default: begin
          id_st <= rnd[2:0];
          ex_st <= rnd[4:3];
        end
      endcase
    end
    @(posedge clk);
    id_st <= '0;
    ex_st <= '0;
    @(posedge clk);
    report_phase("branch", err_br);

    // WFI sleep with two lengths
    phase <= PH_SLEEP;
    for (int k = 0; k < 2; k++) begin
      @(posedge clk);
      wb_st <= '{instr_valid: 1'b1, wfi_insn: 1'b1, default: 1'b0};
      @(posedge clk);
      wb_st <= '0;
      repeat (3 + 2 * k) @(posedge clk);
      irq_wu_i <= 1'b1;
      @(posedge clk);
      irq_wu_i <= 1'b0;
      repeat (2) @(posedge clk);
    end
    report_phase("sleep", err_sleep);

    // Debug request behind an LSU and a later dret
    phase <= PH_DBG;
    @(posedge clk);
    wb_st       <= '{instr_valid: 1'b1, lsu_en: 1'b1, default: 1'b0};
    debug_req_i <= 1'b1;
    @(posedge clk);
    debug_req_i <= 1'b0;
    repeat (3) @(posedge clk);
    wb_st <= '0;
    wait_debug_mode(10);
    repeat (2) @(posedge clk);
    wb_st <= '{instr_valid: 1'b1, dret_insn: 1'b1, default: 1'b0};
    @(posedge clk);
    wb_st <= '0;
    repeat (4) @(posedge clk);
    report_phase("debug", err_dbg);

    total = err_boot + err_exc + err_irq + err_br + err_sleep + err_dbg;
    $display("failures: boot %0d, exc %0d, irq %0d, branch %0d, sleep %0d, debug %0d",
             err_boot, err_exc, err_irq, err_br, err_sleep, err_dbg);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* build.f */
design/ctrl_pkg.sv
design/pipe_event_decode.sv
design/halt_req_arbiter.sv
design/ctrl_sequencer.sv
design/pipe_ctrl_top.sv
tb/tb_pipe_ctrl.sv

/* Bender.yml */
package:
  name: pipe_ctrl

sources:
  - files:
      - design/ctrl_pkg.sv
      - design/pipe_event_decode.sv
      - design/halt_req_arbiter.sv
      - design/ctrl_sequencer.sv
      - design/pipe_ctrl_top.sv
  - target: test
    files:
      - tb/tb_pipe_ctrl.sv
